/* verilog/lorenz_defines.svh */
`ifndef LORENZ_DEFINES_SVH
`define LORENZ_DEFINES_SVH

// ======================================================================
// Fixed-point format for the Lorenz solver
// ======================================================================

// Signed 7.20 value
`define FIX_WIDTH 27
`define FIX_FRAC 20

// Full product of two fixed-point operands
`define PROD_WIDTH 54

// Highest product bit kept below the sign bit
// Bits PROD_TOP..FIX_FRAC give 26 bits, plus the sign
`define PROD_TOP 45

`endif

/* verilog/lorenz_pkg.sv */
`include "lorenz_defines.svh"

package lorenz_pkg;

	// ======================================================================
	// Fixed-point scalars
	// ======================================================================

	// One signed 7.20 value
	typedef logic signed [`FIX_WIDTH-1:0] fix_t;

	// Untruncated product of two fix_t
	typedef logic signed [`PROD_WIDTH-1:0] prod_t;

	// ======================================================================
	// Bundles
	// ======================================================================

	// Point on the attractor
	typedef struct packed {
		fix_t x;
		fix_t y;
		fix_t z;
	} lorenz_state_t;

	// Step size and system coefficients
	typedef struct packed {
		fix_t dt;
		fix_t sigma;
		fix_t rho;
		fix_t beta;
	} lorenz_params_t;

	// Per-step increments, already scaled by dt
	typedef struct packed {
		fix_t dx;
		fix_t dy;
		fix_t dz;
	} lorenz_deriv_t;

	// Step sequencer phases
	typedef enum logic [1:0] {IDLE, DERIVE, UPDATE} step_phase_e;

endpackage

/* verilog/step_control.sv */
`timescale 1ns/100ps
`include "lorenz_defines.svh"

module step_control (
	input  logic clk,
	input  logic reset,
	input  logic load,
	input  logic step,
	output logic derive_en,
	output logic update_en,
	output logic busy,
	output logic done
);

	// ======================================================================
	// Sequencer state
	// ======================================================================

	lorenz_pkg::step_phase_e phase;
	lorenz_pkg::step_phase_e phase_next;
	logic step_accept;

	// New step only from IDLE, and never alongside a load
	assign step_accept = step && !load && (phase == lorenz_pkg::IDLE);

	always_comb begin
		phase_next = phase;
		case (phase)
			lorenz_pkg::IDLE: begin
				if (step_accept) begin
					phase_next = lorenz_pkg::DERIVE;
				end
			end
			// Derivative registers capture at the end of this cycle
			lorenz_pkg::DERIVE: begin
				phase_next = lorenz_pkg::UPDATE;
			end
			// State accumulates at the end of this cycle
			lorenz_pkg::UPDATE: begin
				phase_next = lorenz_pkg::IDLE;
			end
			default: begin
				phase_next = lorenz_pkg::IDLE;
			end
		endcase
		// Load wins over everything and drops the step in flight
		if (load) begin
			phase_next = lorenz_pkg::IDLE;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= lorenz_pkg::IDLE;
			done  <= 1'b0;
		end else begin
			phase <= phase_next;
			// Pulse only for an update that actually landed
			done  <= update_en;
		end
	end

	// ======================================================================
	// Outputs
	// ======================================================================

	assign derive_en = (phase == lorenz_pkg::DERIVE);

	// Masked by load so state takes init alone
	assign update_en = (phase == lorenz_pkg::UPDATE) && !load;

	// Low again in the done cycle, phase is back in IDLE by then
	assign busy = (phase != lorenz_pkg::IDLE);

	// ======================================================================
	// Checks
	// ======================================================================

	// Single-cycle done
	assert property (@(posedge clk) disable iff (reset)
		done |=> !done);

	// UPDATE reached only through DERIVE
	assert property (@(posedge clk) disable iff (reset)
		(phase != lorenz_pkg::DERIVE) |=> (phase != lorenz_pkg::UPDATE));

endmodule

/* verilog/derivative_stage.sv */
`timescale 1ns/100ps
`include "lorenz_defines.svh"

module derivative_stage (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       derive_en,
	input  lorenz_pkg::lorenz_state_t  state,
	input  lorenz_pkg::lorenz_params_t params,
	output lorenz_pkg::lorenz_deriv_t  deriv
);

	// ======================================================================
	// Truncating fixed-point multiply
	// ======================================================================

	// Keep the sign, then product bits PROD_TOP down to FIX_FRAC
	function automatic lorenz_pkg::fix_t fix_mul(
		input lorenz_pkg::fix_t a,
		input lorenz_pkg::fix_t b
	);
		lorenz_pkg::prod_t p;
		p = a * b;
		return {p[`PROD_WIDTH-1], p[`PROD_TOP:`FIX_FRAC]};
	endfunction

	// ======================================================================
	// Derivative arithmetic
	// ======================================================================

	// Differences, wrap in FIX_WIDTH bits
	lorenz_pkg::fix_t y_minus_x;
	lorenz_pkg::fix_t rho_minus_z;

	// First-level products with dt
	lorenz_pkg::fix_t yx_dt;
	lorenz_pkg::fix_t x_dt;
	lorenz_pkg::fix_t y_dt;
	lorenz_pkg::fix_t z_dt;

	// Second-level products
	lorenz_pkg::fix_t sigma_term;
	lorenz_pkg::fix_t rho_term;
	lorenz_pkg::fix_t xy_term;
	lorenz_pkg::fix_t beta_term;

	lorenz_pkg::lorenz_deriv_t deriv_next;

	assign y_minus_x   = state.y - state.x;
	assign rho_minus_z = params.rho - state.z;

	// Products scaled by dt first to keep magnitudes small
	assign yx_dt = fix_mul(y_minus_x, params.dt);
	assign x_dt  = fix_mul(state.x, params.dt);
	assign y_dt  = fix_mul(state.y, params.dt);
	assign z_dt  = fix_mul(state.z, params.dt);

	// x*dt is shared by the dy and dz terms
	assign sigma_term = fix_mul(yx_dt, params.sigma);
	assign rho_term   = fix_mul(x_dt, rho_minus_z);
	assign xy_term    = fix_mul(x_dt, state.y);
	assign beta_term  = fix_mul(params.beta, z_dt);

	// dx = sigma*(y-x)*dt
	assign deriv_next.dx = sigma_term;
	// dy = x*(rho-z)*dt - y*dt
	assign deriv_next.dy = rho_term - y_dt;
	// dz = x*y*dt - beta*z*dt
	assign deriv_next.dz = xy_term - beta_term;

	// ======================================================================
	// Stage register
	// ======================================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			deriv <= '0;
		end else if (derive_en) begin
			deriv <= deriv_next;
		end
	end

	// Coefficients must not move between step accept and capture
	assert property (@(posedge clk) disable iff (reset)
		derive_en |-> $stable(params));

endmodule

/* verilog/state_update.sv */
`timescale 1ns/100ps
`include "lorenz_defines.svh"

module state_update (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      load,
	input  logic                      update_en,
	input  lorenz_pkg::lorenz_state_t init,
	input  lorenz_pkg::lorenz_deriv_t deriv,
	output lorenz_pkg::lorenz_state_t state
);

	// ======================================================================
	// Euler accumulation
	// ======================================================================

	// Next point, each field wraps in FIX_WIDTH bits
	lorenz_pkg::lorenz_state_t state_sum;

	always_comb begin
		state_sum.x = state.x + deriv.dx;
		state_sum.y = state.y + deriv.dy;
		state_sum.z = state.z + deriv.dz;
	end

	// ======================================================================
	// State register
	// ======================================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= '0;
		end else if (load) begin
			// Initial point from the host
			state <= init;
		end else if (update_en) begin
			state <= state_sum;
		end
	end

	// ======================================================================
	// Checks
	// ======================================================================

	// Sequencer masks update_en during a load
	assert property (@(posedge clk) disable iff (reset)
		!(load && update_en));

endmodule

/* verilog/lorenz_top.sv */
`timescale 1ns/100ps
`include "lorenz_defines.svh"

module lorenz_top (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       load,
	input  logic                       step,
	input  lorenz_pkg::lorenz_state_t  init,
	input  lorenz_pkg::lorenz_params_t params,
	output lorenz_pkg::lorenz_state_t  state,
	output logic                       busy,
	output logic                       done
);

	// Stage enables from the sequencer
	logic derive_en;
	logic update_en;

	// Registered increments, stage one to stage two
	lorenz_pkg::lorenz_deriv_t deriv;

	// ======================================================================
	// Step sequencer
	// ======================================================================

	step_control u_step_control (
		.clk       (clk),
		.reset     (reset),
		.load      (load),
		.step      (step),
		.derive_en (derive_en),
		.update_en (update_en),
		.busy      (busy),
		.done      (done)
	);

	// Stage one, derivatives from the current point
	derivative_stage u_derivative_stage (
		.clk       (clk),
		.reset     (reset),
		.derive_en (derive_en),
		.state     (state),
		.params    (params),
		.deriv     (deriv)
	);

	// Stage two, point register and accumulator
	state_update u_state_update (
		.clk       (clk),
		.reset     (reset),
		.load      (load),
		.update_en (update_en),
		.init      (init),
		.deriv     (deriv),
		.state     (state)
	);

endmodule

/* sim/lorenz_checker.sv */
`timescale 1ns/100ps
`include "lorenz_defines.svh"

module lorenz_checker (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       load,
	input  logic                       step,
	input  lorenz_pkg::lorenz_state_t  init,
	input  lorenz_pkg::lorenz_params_t params,
	input  lorenz_pkg::lorenz_state_t  state,
	input  logic                       busy,
	input  logic                       done,
	input  logic [8*16-1:0]            test_name,
	output int                         error_count,
	output int                         check_count
);

	// Model point, and the step result waiting to land
	lorenz_pkg::lorenz_state_t model_state;
	lorenz_pkg::lorenz_state_t model_next;
	// 0 idle, 1 derive, 2 update
	int model_phase;
	logic expect_done;
	logic expect_state;

	// ======================================================================
	// Reference arithmetic
	// ======================================================================

	// Sign bit, then product bits PROD_TOP down to FIX_FRAC
	function automatic lorenz_pkg::fix_t fixed_product(input lorenz_pkg::fix_t a,
			input lorenz_pkg::fix_t b);
		longint wide;
		logic [63:0] bits;
		wide = longint'(a) * longint'(b);
		bits = wide;
		return {bits[63], bits[`PROD_TOP:`FIX_FRAC]};
	endfunction

	// One forward Euler step, sums wrap in 27 bits
	function automatic lorenz_pkg::lorenz_state_t euler_step(input lorenz_pkg::lorenz_state_t s,
			input lorenz_pkg::lorenz_params_t p);
		lorenz_pkg::fix_t dx;
		lorenz_pkg::fix_t dy;
		lorenz_pkg::fix_t dz;
		lorenz_pkg::lorenz_state_t n;
		dx = fixed_product(fixed_product(s.y - s.x, p.dt), p.sigma);
		dy = fixed_product(fixed_product(s.x, p.dt), p.rho - s.z) - fixed_product(s.y, p.dt);
		dz = fixed_product(fixed_product(s.x, p.dt), s.y)
			- fixed_product(p.beta, fixed_product(s.z, p.dt));
		n.x = s.x + dx;
		n.y = s.y + dy;
		n.z = s.z + dz;
		return n;
	endfunction

	task automatic compare_flag(input string what, input logic expected, input logic actual);
		check_count++;
		if (expected !== actual) begin
			error_count++;
			$display("[FAIL] %0s %0s expected %b actual %b", test_name, what, expected, actual);
		end
	endtask

	task automatic compare_point(input lorenz_pkg::lorenz_state_t expected);
		check_count++;
		if (expected !== state) begin
			error_count++;
			$display("[FAIL] %0s state expected %h actual %h", test_name, expected, state);
		end
	endtask

	// ======================================================================
	// Cycle model
	// ======================================================================

	always @(posedge clk) begin
		if (reset) begin
			model_state = '0;
			model_phase = 0;
			expect_done = 1'b0;
			// Zero state is checked on the first cycle out of reset
			expect_state = 1'b1;
			error_count = 0;
			check_count = 0;
		end else begin
			// Outputs of the cycle that just ended
			compare_flag("done", expect_done, done);
			compare_flag("busy", model_phase != 0, busy);
			if (expect_done || expect_state) begin
				compare_point(model_state);
			end
			expect_done = 1'b0;
			expect_state = 1'b0;
			// Inputs sampled at this edge, load first
			if (load) begin
				model_state = init;
				model_phase = 0;
				expect_state = 1'b1;
			end else begin
				case (model_phase)
					0: begin
						if (step) begin
							model_next = euler_step(model_state, params);
							model_phase = 1;
						end
					end
					1: model_phase = 2;
					default: begin
						model_state = model_next;
						model_phase = 0;
						expect_done = 1'b1;
					end
				endcase
			end
		end
	end

endmodule

/* sim/tb_lorenz.sv */
`timescale 1ns/100ps

module tb_lorenz;

	logic clk;
	logic reset;
	logic load;
	logic step;
	lorenz_pkg::lorenz_state_t init;
	lorenz_pkg::lorenz_params_t params;
	lorenz_pkg::lorenz_state_t state;
	lorenz_pkg::lorenz_state_t start_point;
	logic busy;
	logic done;
	logic [8*16-1:0] test_name;
	int error_count;
	int check_count;
	int errors_before;
	logic [31:0] seed;

	// 8 ns period
	always #4 clk = ~clk;

	lorenz_top dut (
		.clk    (clk),
		.reset  (reset),
		.load   (load),
		.step   (step),
		.init   (init),
		.params (params),
		.state  (state),
		.busy   (busy),
		.done   (done)
	);

	lorenz_checker u_checker (
		.clk         (clk),
		.reset       (reset),
		.load        (load),
		.step        (step),
		.init        (init),
		.params      (params),
		.state       (state),
		.busy        (busy),
		.done        (done),
		.test_name   (test_name),
		.error_count (error_count),
		.check_count (check_count)
	);

	// ======================================================================
	// Random values
	// ======================================================================

	function automatic logic [31:0] xorshift(input logic [31:0] v);
		logic [31:0] r;
		r = v ^ (v << 13);
		r = r ^ (r >> 17);
		r = r ^ (r << 5);
		return r;
	endfunction

	// Fixed-point value in [low, high), both in units of 2^-20
	function automatic lorenz_pkg::fix_t random_range(input int low, input int high);
		seed = xorshift(seed);
		return lorenz_pkg::fix_t'(low + int'(seed % (high - low)));
	endfunction

	// Point inside +-16 on each axis
	function automatic lorenz_pkg::lorenz_state_t random_point();
		lorenz_pkg::lorenz_state_t p;
		p.x = random_range(-(16 << 20), 16 << 20);
		p.y = random_range(-(16 << 20), 16 << 20);
		p.z = random_range(-(16 << 20), 16 << 20);
		return p;
	endfunction

	// ======================================================================
	// Stimulus tasks
	// ======================================================================

	task automatic start_test(input logic [8*16-1:0] name);
		@(negedge clk);
		test_name = name;
		errors_before = error_count;
	endtask

	task automatic finish_test();
		@(negedge clk);
		$display("test %0s: %0d errors", test_name, error_count - errors_before);
	endtask

	task automatic load_point(input lorenz_pkg::lorenz_state_t point);
		@(posedge clk);
		load <= 1'b1;
		init <= point;
		@(posedge clk);
		load <= 1'b0;
	endtask

	task automatic wait_done();
		int cycles;
		cycles = 0;
		while (!done && cycles < 20) begin
			@(posedge clk);
			cycles++;
		end
		if (!done) begin
			$display("Timeout: no done pulse within 20 cycles in test %0s", test_name);
			$display("Verification failed");
			$finish;
		end
	endtask

	task automatic wait_idle();
		int cycles;
		cycles = 0;
		while (busy && cycles < 20) begin
			@(posedge clk);
			cycles++;
		end
		if (busy) begin
			$display("Timeout: busy stuck high in test %0s", test_name);
			$display("Verification failed");
			$finish;
		end
	endtask

	task automatic run_step();
		@(posedge clk);
		step <= 1'b1;
		@(posedge clk);
		step <= 1'b0;
		wait_done();
	endtask

	// Load lands in DERIVE for 1, in UPDATE for 2
	task automatic cancel_step(input int phase_cycles);
		@(posedge clk);
		step <= 1'b1;
		@(posedge clk);
		step <= 1'b0;
		repeat (phase_cycles - 1) @(posedge clk);
		load <= 1'b1;
		init <= random_point();
		@(posedge clk);
		load <= 1'b0;
		repeat (4) @(posedge clk);
	endtask

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		load = 1'b0;
		step = 1'b0;
		init = '0;
		params = '0;
		seed = 32'hefaa_525d;
		test_name = "after_reset";
		errors_before = 0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;

		start_test("after_reset");
		repeat (3) @(posedge clk);
		finish_test();

		start_test("load_point");
		load_point(random_point());
		repeat (3) @(posedge clk);
		finish_test();

		// sigma 10, rho 28, beta 8/3, dt 1/256
		start_test("single_step");
		@(posedge clk);
		params <= '{dt: 27'sd4096, sigma: 27'sd10485760, rho: 27'sd29360128,
			beta: 27'sd2796203};
		load_point(random_point());
		run_step();
		finish_test();

		start_test("classic_run");
		start_point.x = 27'sd1048576;
		start_point.y = 27'sd1048576;
		start_point.z = 27'sd1048576;
		load_point(start_point);
		for (int i = 0; i < 500; i++) begin
			run_step();
		end
		finish_test();

		// dt 1/2048..1/256, sigma 1..12, rho 1..28, beta 0.5..3
		start_test("random_run");
		@(posedge clk);
		params <= '{dt: random_range(512, 4097), sigma: random_range(1 << 20, 12 << 20),
			rho: random_range(1 << 20, 28 << 20), beta: random_range(1 << 19, 3 << 20)};
		load_point(random_point());
		for (int i = 0; i < 500; i++) begin
			run_step();
		end
		finish_test();

		// Step held high across whole steps
		start_test("ignored_steps");
		load_point(random_point());
		@(posedge clk);
		step <= 1'b1;
		repeat (15) @(posedge clk);
		step <= 1'b0;
		wait_idle();
		repeat (4) @(posedge clk);
		finish_test();

		start_test("load_cancel");
		load_point(random_point());
		cancel_step(1);
		run_step();
		cancel_step(2);
		run_step();
		finish_test();

		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	// Whole-run limit
	initial begin
		#1000000;
		$display("Simulation time limit reached in test %0s", test_name);
		$display("Verification failed");
		$finish;
	end

endmodule

/* lorenz.f */
+incdir+verilog
verilog/lorenz_pkg.sv
verilog/step_control.sv
verilog/derivative_stage.sv
verilog/state_update.sv
verilog/lorenz_top.sv
sim/lorenz_checker.sv
sim/tb_lorenz.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the Lorenz solver testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_lorenz \
	-f lorenz.f \
	-o sim_lorenz

# Output goes to the terminal and is searched for the result line
output=$(./obj_dir/sim_lorenz)
echo "$output"

if echo "$output" | grep -qx "Verification passed"; then
	echo "Simulation run passed"
	exit 0
fi

echo "Simulation run failed"
exit 1
